// ==== Makefile ====
# Verilator build and run of the floor request controller testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_floor_logic
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/car_dispatch.sv ====
// Purely combinational, and a stale top is popped whether or not requests are enabled
`default_nettype none

module car_dispatch (
    input  elevator_pkg::car_mode_t      mode,
    input  elevator_pkg::car_status_t    car,
    input  wire                          door_open_button,
    input  wire                          door_close_button,
    input  elevator_pkg::floor_mask_t    pending_floors,
    input  elevator_pkg::floor_t         top_floor,
    input  wire                          stack_empty,
    output elevator_pkg::floor_service_t service,
    output logic                         pop,
    output elevator_pkg::floor_t         target_floor,
    output logic                         direction_up,
    output logic                         activate,
    output logic                         door_open_allowed,
    output logic                         door_close_allowed
);

    logic                      enabled;
    logic                      stopped;
    elevator_pkg::floor_mask_t top_mask;
    logic                      top_pending;
    logic                      door_ok;

    assign enabled = mode.power && !mode.emergency;

    // Stop codes sit below every travel and emergency code
    assign stopped = (car.state <= elevator_pkg::STATE_W'(elevator_pkg::STOP_LAST));

    assign top_mask    = elevator_pkg::floor_mask_t'(1) << top_floor;
    assign top_pending = |(pending_floors & top_mask);

    //////////////////////////////////////////////////////////////////////
    // Request bookkeeping
    //////////////////////////////////////////////////////////////////////

    // Lamps of the floor the car stands at go out on the next edge
    always_comb begin
        service.valid = enabled && stopped;
        service.floor = car.floor;
    end

    // An entry whose lamps are already out has been served on an earlier stop
    assign pop = !stack_empty && !top_pending;

    //////////////////////////////////////////////////////////////////////
    // Dispatch to the car
    //////////////////////////////////////////////////////////////////////

    assign activate = enabled && stopped && !stack_empty && top_pending
                      && (top_floor != car.floor);

    always_comb begin
        if (activate) begin
            target_floor = top_floor;
            direction_up = (top_floor > car.floor);
        end else begin
            target_floor = car.floor;
            direction_up = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Doors
    //////////////////////////////////////////////////////////////////////

    // Emergency does not lock the doors, only power loss or travel does
    assign door_ok            = stopped && mode.power;
    assign door_open_allowed  = door_ok && door_open_button;
    assign door_close_allowed = door_ok && door_close_button;

endmodule

`default_nettype wire

// ==== design/elevator_pkg.sv ====
// Floors are numbered from zero and the car reports state codes 0 to 10 as stopped at that floor
`default_nettype none

package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_FLOORS  = 11;
    localparam int FLOOR_W     = 4;
    localparam int STATE_W     = 6;
    localparam int STACK_DEPTH = 11;

    // Car state codes
    // 0 to 10 stopped at floor, 11 to 30 travelling between floors
    localparam int STOP_LAST       = 10;
    localparam int EMERGENCY_STATE = 31;

    //////////////////////////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////////////////////////

    typedef logic [FLOOR_W-1:0]    floor_t;
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Status reported by the car state machine
    typedef struct packed {
        logic [STATE_W-1:0] state;
        floor_t             floor;
    } car_status_t;

    // Operator levels
    typedef struct packed {
        logic power;
        logic emergency;
    } car_mode_t;

    // One-cycle request to put a floor on the stack
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_push_t;

    // Level that holds while the car stands at a floor
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_service_t;

endpackage

`default_nettype wire

// ==== design/floor_logic_top.sv ====
// The car state machine is external and must keep car.floor equal to the stop code while stopped
`default_nettype none

module floor_logic_top (
    input  wire                       clock,
    input  wire                       reset_n,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  elevator_pkg::floor_mask_t call_buttons,
    input  wire                       door_open_button,
    input  wire                       door_close_button,
    input  elevator_pkg::car_mode_t   mode,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::floor_t      target_floor,
    output logic                      direction_up,
    output logic                      activate,
    output elevator_pkg::floor_mask_t panel_lights,
    output elevator_pkg::floor_mask_t call_lights,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    elevator_pkg::floor_push_t    push;
    elevator_pkg::floor_mask_t    pending_floors;
    elevator_pkg::floor_service_t service;
    elevator_pkg::floor_t         top_floor;
    logic                         clear_all;
    logic                         pop;
    logic                         stack_empty;
    logic                         stack_full;

    // Button lamps and push decisions
    floor_request_latch u_latch (
        .clock          (clock),
        .reset_n        (reset_n),
        .panel_buttons  (panel_buttons),
        .call_buttons   (call_buttons),
        .mode           (mode),
        .current_floor  (car.floor),
        .service        (service),
        .stack_full     (stack_full),
        .panel_lights   (panel_lights),
        .call_lights    (call_lights),
        .pending_floors (pending_floors),
        .push           (push),
        .clear_all      (clear_all)
    );

    // Pending floors, newest on top
    request_stack u_stack (
        .clock     (clock),
        .reset_n   (reset_n),
        .push      (push),
        .pop       (pop),
        .clear_all (clear_all),
        .top_floor (top_floor),
        .empty     (stack_empty),
        .full      (stack_full)
    );

    // Target selection and door permits
    car_dispatch u_dispatch (
        .mode               (mode),
        .car                (car),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .pending_floors     (pending_floors),
        .top_floor          (top_floor),
        .stack_empty        (stack_empty),
        .service            (service),
        .pop                (pop),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate           (activate),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

// ==== design/floor_request_latch.sv ====
// Accepts one press per cycle with panel buttons ahead of call buttons, and the stack must not be full
`default_nettype none

module floor_request_latch (
    input  wire                          clock,
    input  wire                          reset_n,
    input  elevator_pkg::floor_mask_t    panel_buttons,
    input  elevator_pkg::floor_mask_t    call_buttons,
    input  elevator_pkg::car_mode_t      mode,
    input  elevator_pkg::floor_t         current_floor,
    input  elevator_pkg::floor_service_t service,
    input  wire                          stack_full,
    output elevator_pkg::floor_mask_t    panel_lights,
    output elevator_pkg::floor_mask_t    call_lights,
    output elevator_pkg::floor_mask_t    pending_floors,
    output elevator_pkg::floor_push_t    push,
    output logic                         clear_all
);

    logic                      enabled;
    elevator_pkg::floor_mask_t here_mask;
    elevator_pkg::floor_mask_t panel_cand;
    elevator_pkg::floor_mask_t call_cand;
    elevator_pkg::floor_mask_t cand;
    logic                      from_panel;
    elevator_pkg::floor_t      pick_floor;
    elevator_pkg::floor_mask_t pick_mask;
    logic                      press_valid;
    logic                      already_pending;
    logic                      accept;
    elevator_pkg::floor_mask_t panel_set;
    elevator_pkg::floor_mask_t call_set;
    elevator_pkg::floor_mask_t service_mask;

    assign enabled   = mode.power && !mode.emergency;
    assign clear_all = !enabled;

    //////////////////////////////////////////////////////////////////////
    // Press selection
    //////////////////////////////////////////////////////////////////////

    // Presses at the floor the car is on, or on a lit lamp, are not new
    assign here_mask  = elevator_pkg::floor_mask_t'(1) << current_floor;
    assign panel_cand = panel_buttons & ~panel_lights & ~here_mask;
    assign call_cand  = call_buttons & ~call_lights & ~here_mask;

    assign from_panel = |panel_cand;
    assign cand       = from_panel ? panel_cand : call_cand;

    // Lowest floor wins
    always_comb begin
        pick_floor = '0;
        for (int i = elevator_pkg::NUM_FLOORS - 1; i >= 0; i--) begin
            if (cand[i]) begin
                pick_floor = elevator_pkg::floor_t'(i);
            end
        end
    end

    assign pick_mask       = elevator_pkg::floor_mask_t'(1) << pick_floor;
    assign press_valid     = enabled && (|cand);
    assign already_pending = |(pending_floors & pick_mask);

    // A floor that needs a new stack slot is dropped while the stack is full
    assign accept = press_valid && (already_pending || !stack_full);

    always_comb begin
        push.valid = press_valid && !already_pending && !stack_full;
        push.floor = pick_floor;
    end

    assign panel_set = (accept && from_panel) ? pick_mask : '0;
    assign call_set  = (accept && !from_panel) ? pick_mask : '0;

    //////////////////////////////////////////////////////////////////////
    // Lamp registers
    //////////////////////////////////////////////////////////////////////

    assign service_mask = service.valid ? (elevator_pkg::floor_mask_t'(1) << service.floor) : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else if (clear_all) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else begin
            // Set and service never hit the same floor since the car's floor is excluded
            panel_lights <= (panel_lights | panel_set) & ~service_mask;
            call_lights  <= (call_lights | call_set) & ~service_mask;
        end
    end

    assign pending_floors = panel_lights | call_lights;

endmodule

`default_nettype wire

// ==== design/request_stack.sv ====
// Pushing while full or popping while empty is left undefined since neither neighbour issues one
`default_nettype none

module request_stack (
    input  wire                       clock,
    input  wire                       reset_n,
    input  elevator_pkg::floor_push_t push,
    input  wire                       pop,
    input  wire                       clear_all,
    output elevator_pkg::floor_t      top_floor,
    output logic                      empty,
    output logic                      full
);

    typedef logic [$clog2(elevator_pkg::STACK_DEPTH + 1) - 1:0] count_t;

    elevator_pkg::floor_t entries [elevator_pkg::STACK_DEPTH];
    count_t               count;
    count_t               top_idx;
    count_t               wr_idx;
    logic                 replace;

    assign empty   = (count == '0);
    assign full    = (count == count_t'(elevator_pkg::STACK_DEPTH));
    assign top_idx = count - count_t'(1);

    // Push together with pop overwrites the top slot in place
    assign replace = push.valid && pop;
    assign wr_idx  = replace ? top_idx : count;

    //////////////////////////////////////////////////////////////////////
    // Occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (clear_all) begin
            count <= '0;
        end else if (replace) begin
            count <= count;
        end else if (push.valid) begin
            count <= count + count_t'(1);
        end else if (pop) begin
            count <= count - count_t'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push.valid && !clear_all) begin
            entries[wr_idx] <= push.floor;
        end
    end

    // Slots above the count hold old floors and are never shown
    assign top_floor = empty ? elevator_pkg::floor_t'(0) : entries[top_idx];

endmodule

`default_nettype wire

// ==== sources.f ====
design/elevator_pkg.sv
design/floor_request_latch.sv
design/request_stack.sv
design/car_dispatch.sv
design/floor_logic_top.sv
tb/floor_logic_properties.sv
tb/tb_floor_logic.sv

// ==== tb/floor_logic_properties.sv ====
// Checks only dispatch and door invariants at the top level, and nothing while reset_n is low
`default_nettype none

module floor_logic_properties (
    input  wire                       clock,
    input  wire                       reset_n,
    input  elevator_pkg::car_mode_t   mode,
    input  elevator_pkg::car_status_t car,
    input  elevator_pkg::floor_t      target_floor,
    input  wire                       activate,
    input  wire                       door_open_allowed,
    input  wire                       door_close_allowed
);

    timeunit 1ns;
    timeprecision 1ps;

    // The car only leaves from a stop code
    activate_needs_stop: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate |-> (car.state <= elevator_pkg::STATE_W'(elevator_pkg::STOP_LAST))
    ) else $error("activate is high while the car is not stopped");

    activate_needs_move: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate |-> (target_floor != car.floor)
    ) else $error("activate is high with the target equal to the current floor");

    // Door permits drop with power
    doors_need_power: assert property (
        @(posedge clock) disable iff (!reset_n)
        !mode.power |-> (!door_open_allowed && !door_close_allowed)
    ) else $error("a door permit is high while power is off");

endmodule

bind floor_logic_top floor_logic_properties i_props (
    .clock              (clock),
    .reset_n            (reset_n),
    .mode               (mode),
    .car                (car),
    .target_floor       (target_floor),
    .activate           (activate),
    .door_open_allowed  (door_open_allowed),
    .door_close_allowed (door_close_allowed)
);

`default_nettype wire

// ==== tb/tb_floor_logic.sv ====
// Random test from a fixed LFSR seed with a car model that travels one floor per four cycles
`default_nettype none

module tb_floor_logic;

    timeunit 1ns;
    timeprecision 1ps;

    // Five phases of at most about a thousand cycles each
    localparam int CYCLE_LIMIT = 6000;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::floor_mask_t panel_buttons, call_buttons;
    logic                      door_open_button, door_close_button;
    elevator_pkg::car_mode_t   mode;
    elevator_pkg::car_status_t car;
    elevator_pkg::floor_t      target_floor;
    logic                      direction_up, activate;
    elevator_pkg::floor_mask_t panel_lights, call_lights;
    logic                      door_open_allowed, door_close_allowed;

    // Input values for the next rising edge
    elevator_pkg::floor_mask_t next_panel, next_call;
    logic                      next_door_open, next_door_close;
    elevator_pkg::car_mode_t   next_mode;

    // Reference model with the newest floor at the back of the queue
    elevator_pkg::floor_mask_t model_panel, model_call;
    int                        model_stack [$];
    int                        max_count, ignored, exp_target;
    logic                      exp_activate, exp_up;

    // Car model
    logic  car_run, car_moving, car_up;
    int    car_state, car_floor, car_goal, car_tick, car_dwell, arrivals;

    logic [15:0] lfsr;
    int          cycles = 0;
    string       phase_name;

    floor_logic_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and helpers
    //////////////////////////////////////////////////////////////////////

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = (r << 1) | {31'd0, lfsr[0]};
        end
        return r;
    endfunction

    function automatic int random_floor();
        return int'(take_bits(4) % 11);
    endfunction

    function automatic elevator_pkg::floor_mask_t floor_bit(input int f);
        return elevator_pkg::floor_mask_t'(1) << f;
    endfunction

    function automatic logic has_floor(input elevator_pkg::floor_mask_t m, input int f);
        return |(m & floor_bit(f));
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("error: %s %s expected %0d actual %0d", phase_name, name, expected, actual);
            abort_run();
        end
    endtask

    // A press chance of one in 2**k per bank
    task automatic drive_presses(input int k);
        next_panel      = (take_bits(k) == 0) ? floor_bit(random_floor()) : '0;
        next_call       = (take_bits(k) == 0) ? floor_bit(random_floor()) : '0;
        next_door_open  = (take_bits(1) != 0);
        next_door_close = (take_bits(1) != 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int lowest_press(input elevator_pkg::floor_mask_t buttons,
                                        input elevator_pkg::floor_mask_t lamps);
        for (int i = 0; i < elevator_pkg::NUM_FLOORS; i++) begin
            if (has_floor(buttons & ~lamps, i) && i != int'(car.floor)) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic compare_outputs();
        elevator_pkg::floor_mask_t pending;
        logic                      stopped;
        int                        top;
        pending = model_panel | model_call;
        stopped = int'(car.state) <= elevator_pkg::STOP_LAST;
        top = (model_stack.size() > 0) ? model_stack[$] : 0;
        exp_activate = mode.power && !mode.emergency && stopped && model_stack.size() > 0
                       && has_floor(pending, top) && top != int'(car.floor);
        exp_target = exp_activate ? top : int'(car.floor);
        exp_up = exp_activate && (top > int'(car.floor));
        check_value("panel_lights", int'(model_panel), int'(panel_lights));
        check_value("call_lights", int'(model_call), int'(call_lights));
        check_value("activate", int'(exp_activate), int'(activate));
        check_value("target_floor", exp_target, int'(target_floor));
        check_value("direction_up", int'(exp_up), int'(direction_up));
        check_value("door_open_allowed", int'(stopped && mode.power && door_open_button),
                    int'(door_open_allowed));
        check_value("door_close_allowed", int'(stopped && mode.power && door_close_button),
                    int'(door_close_allowed));
    endtask

    task automatic advance_model();
        elevator_pkg::floor_mask_t pending;
        int                        sel;
        logic                      from_panel, do_push, do_pop;
        pending = model_panel | model_call;
        sel = lowest_press(panel_buttons, model_panel);
        from_panel = (sel >= 0);
        if (!from_panel) begin
            sel = lowest_press(call_buttons, model_call);
        end
        do_pop = model_stack.size() > 0 && !has_floor(pending, model_stack[$]);
        do_push = 1'b0;
        if (!mode.power || mode.emergency) begin
            model_panel = '0;
            model_call = '0;
            model_stack.delete();
        end else begin
            if (sel >= 0 && !has_floor(pending, sel)
                && model_stack.size() == elevator_pkg::STACK_DEPTH) begin
                ignored++;
            end else if (sel >= 0) begin
                do_push = !has_floor(pending, sel);
                if (from_panel) begin
                    model_panel = model_panel | floor_bit(sel);
                end else begin
                    model_call = model_call | floor_bit(sel);
                end
            end
            // Lamps of the floor the car stands at
            if (int'(car.state) <= elevator_pkg::STOP_LAST) begin
                model_panel = model_panel & ~floor_bit(int'(car.floor));
                model_call = model_call & ~floor_bit(int'(car.floor));
            end
            if (do_pop) begin
                void'(model_stack.pop_back());
            end
            if (do_push) begin
                model_stack.push_back(sel);
            end
            max_count = (model_stack.size() > max_count) ? model_stack.size() : max_count;
        end
    endtask

    // Travel codes 11 to 20 going up, 21 to 30 going down
    task automatic advance_car();
        if (car_moving) begin
            car_tick++;
            if (car_tick == 4) begin
                car_tick = 0;
                car_floor = car_up ? car_floor + 1 : car_floor - 1;
                if (car_floor == car_goal) begin
                    car_moving = 1'b0;
                    car_state = car_floor;
                    car_dwell = 3;
                    arrivals++;
                end else begin
                    car_state = car_up ? 11 + car_floor : 20 + car_floor;
                end
            end
        end else if (car_dwell > 0) begin
            car_dwell--;
        end else if (exp_activate) begin
            car_moving = 1'b1;
            car_goal = exp_target;
            car_up = exp_up;
            car_tick = 0;
            car_state = car_up ? 11 + car_floor : 20 + car_floor;
        end
    endtask

    // Check at the falling edge, then drive at the rising edge
    task automatic step();
        @(negedge clock);
        compare_outputs();
        advance_model();
        if (car_run) begin
            advance_car();
        end
        @(posedge clock);
        panel_buttons     <= next_panel;
        call_buttons      <= next_call;
        door_open_button  <= next_door_open;
        door_close_button <= next_door_close;
        mode              <= next_mode;
        car.state         <= elevator_pkg::STATE_W'(car_state);
        car.floor         <= elevator_pkg::floor_t'(car_floor);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Phases
    //////////////////////////////////////////////////////////////////////

    initial begin
        lfsr = 16'd24;
        reset_n = 1'b0;
        panel_buttons = '0;
        call_buttons = '0;
        door_open_button = 1'b0;
        door_close_button = 1'b0;
        mode = '{power: 1'b1, emergency: 1'b0};
        car = '0;
        next_panel = '0;
        next_call = '0;
        next_door_open = 1'b0;
        next_door_close = 1'b0;
        next_mode = mode;
        model_panel = '0;
        model_call = '0;
        {max_count, ignored, arrivals, car_state, car_floor, car_tick, car_dwell} = '0;
        {car_run, car_moving, car_up} = '0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        phase_name = "reset";
        repeat (8) step();

        // Car parked while lamps follow single presses
        phase_name = "single_press";
        for (int c = 0; c < 400; c++) begin
            if (c % 50 == 0) begin
                car_floor = random_floor();
                car_state = car_floor;
            end
            drive_presses(1);
            step();
        end

        phase_name = "car_service";
        car_run = 1'b1;
        while (arrivals < 12) begin
            drive_presses(2);
            step();
        end
        next_panel = '0;
        next_call = '0;
        while (model_stack.size() != 0 || car_moving) begin
            step();
        end

        // Mostly travelling with short stops that leave buried stale entries
        phase_name = "stack_full";
        car_run = 1'b0;
        max_count = 0;
        ignored = 0;
        for (int c = 0; c < 600; c++) begin
            if (c % 8 == 0) begin
                car_floor = random_floor();
                car_state = (take_bits(1) != 0) ? car_floor : 20;
            end else begin
                car_state = 20;
            end
            drive_presses(0);
            step();
        end
        check_value("stack_fill", elevator_pkg::STACK_DEPTH, max_count);
        check_value("ignored_press_seen", 1, int'(ignored > 0));

        phase_name = "power_pulses";
        car_state = car_floor;
        car_run = 1'b1;
        for (int c = 0; c < 800; c++) begin
            next_mode.power = (take_bits(5) != 0);
            next_mode.emergency = (take_bits(5) == 0);
            drive_presses(1);
            step();
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
